//--- Makefile
# Verilator build and run of the DMA engine testbench

RTL := source/dma_bus_pkg.sv source/dma_ctrl_pkg.sv source/dma_cycle_timer.sv \
       source/sprite_dma_engine.sv source/dma_bus_arbiter.sv source/nes_dma_top.sv

.PHONY: all lint clean

all: obj_dir/Vtb_nes_dma
	./obj_dir/Vtb_nes_dma | tee sim.log
	grep -q "Result: PASSED" sim.log

obj_dir/Vtb_nes_dma: list.f $(RTL) verification/tb_nes_dma.sv verification/dma_vectors.txt
	verilator --binary --timing -f list.f --top-module tb_nes_dma

lint:
	verilator --lint-only -Wall --top-module nes_dma_top $(RTL)

clean:
	rm -rf obj_dir sim.log

//--- list.f
source/dma_bus_pkg.sv
source/dma_ctrl_pkg.sv
source/dma_cycle_timer.sv
source/sprite_dma_engine.sv
source/dma_bus_arbiter.sv
source/nes_dma_top.sv
verification/tb_nes_dma.sv

//--- source/dma_bus_arbiter.sv
//####################################################################
// DMA bus arbiter
// Runs the sample channel handshake, decodes the sprite DMA trigger
// and multiplexes the bus between the CPU and the two DMA sources
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module dma_bus_arbiter (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         cpu_ce,
	input  wire                         odd_cycle,
	input  wire                         sample_request,   // Level, held until the ack
	input  wire  dma_bus_pkg::cpu_bus_t cpu,
	input  wire  dma_bus_pkg::addr_t    sample_addr,
	input  wire  dma_ctrl_pkg::sprite_state_e sprite_state,
	input  wire  dma_bus_pkg::addr_t    sprite_addr,
	input  wire  dma_bus_pkg::data_t    sprite_data,
	output logic                        oam_trigger,      // Write to the sprite DMA register
	output logic                        sample_grant,
	output logic                        sample_ack,       // One even CPU cycle wide
	output logic                        pause_cpu,
	output dma_bus_pkg::dma_bus_t       bus
);

	dma_ctrl_pkg::sample_state_e sample_state;

	logic sprite_copy;    // Sprite engine is copying
	logic sprite_pause;   // Sprite engine is pending or copying
	logic dma_owner;      // Either DMA source drives the bus

	// Sample channel
	// Granted at the end of an even CPU read, ack in the following even cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			sample_state <= dma_ctrl_pkg::SAMPLE_IDLE;
		end else if (cpu_ce) begin
			case (sample_state)
				dma_ctrl_pkg::SAMPLE_IDLE: begin
					if (sample_request && cpu.rnw && !odd_cycle) begin
						sample_state <= dma_ctrl_pkg::SAMPLE_GRANTED;
					end
				end
				dma_ctrl_pkg::SAMPLE_GRANTED: begin
					if (!odd_cycle) begin
						sample_state <= dma_ctrl_pkg::SAMPLE_IDLE;   // Ack cycle is over
					end
				end
				default: sample_state <= dma_ctrl_pkg::SAMPLE_IDLE;
			endcase
		end
	end

	assign sample_grant = (sample_state == dma_ctrl_pkg::SAMPLE_GRANTED);
	assign sample_ack   = sample_grant && !odd_cycle;   // Odd half of the grant leaves the bus idle

	// Sprite state bits carry their meaning directly
	assign sprite_pause = sprite_state[0];
	assign sprite_copy  = sprite_state[1];

	// Requester stalls the CPU as soon as it asks
	assign pause_cpu = sprite_pause || sample_request;

	assign dma_owner = sample_ack || sprite_copy;

	// Bus multiplexer
	always_comb begin
		bus.owner = dma_owner;
		if (dma_owner) begin
			bus.read = !odd_cycle;   // DMA reads on even, writes on odd
			bus.data = sprite_data;  // Only the sprite engine ever writes
			if (sample_ack) begin
				bus.addr = sample_addr;   // Sample fetch wins the even cycle
			end else if (!odd_cycle) begin
				bus.addr = sprite_addr;
			end else begin
				bus.addr = dma_bus_pkg::OAM_DATA_PORT;
			end
		end else begin
			bus.addr = cpu.addr;   // CPU passes straight through
			bus.data = cpu.dout;
			bus.read = cpu.rnw;
		end
	end

	// Trigger decoded from the outgoing bus
	// DMA itself never writes this address
	assign oam_trigger = (bus.addr == dma_bus_pkg::OAM_DMA_REG) && !bus.read;

endmodule

`default_nettype wire

//--- source/dma_bus_pkg.sv
//####################################################################
// DMA bus package
// Bus widths, register addresses and the packed bus bundles shared
// by the CPU side and the DMA side of the engine
//####################################################################
`default_nettype none

package dma_bus_pkg;

	// Bus widths
	localparam int unsigned ADDR_W = 16;
	localparam int unsigned DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;   // CPU address space
	typedef logic [DATA_W-1:0] data_t;   // One bus byte

	// Register map, only what the DMA decodes or drives
	localparam addr_t OAM_DMA_REG   = 16'h4014;   // Sprite DMA trigger, written with the page
	localparam addr_t OAM_DATA_PORT = 16'h2004;   // OAM data port, target of every odd cycle

	// Bus as it leaves the CPU core
	typedef struct packed {
		addr_t addr;   // Address of the current cycle
		data_t dout;   // Write data, only valid when rnw is low
		logic  rnw;    // 1 = read, 0 = write
	} cpu_bus_t;

	// Bus after the DMA multiplexer
	typedef struct packed {
		addr_t addr;    // Outgoing address
		data_t data;    // Outgoing write data
		logic  read;    // 1 = read, 0 = write
		logic  owner;   // DMA has taken the bus this cycle
	} dma_bus_t;

endpackage

`default_nettype wire

//--- source/dma_ctrl_pkg.sv
//####################################################################
// DMA control package
// Cycle divider constants, sprite copy limits and the state
// encodings of the sprite engine and the sample channel
//####################################################################
`default_nettype none

package dma_ctrl_pkg;

	// Master clocks per CPU cycle
	localparam int unsigned CPU_DIVIDE = 12;
	localparam int unsigned DIVIDE_W   = $clog2(CPU_DIVIDE + 1);

	typedef logic [DIVIDE_W-1:0] divide_t;
	localparam divide_t DIVIDE_FIRST = divide_t'(1);            // Counter value after a wrap
	localparam divide_t DIVIDE_LAST  = divide_t'(CPU_DIVIDE);   // Cycle enable fires here

	// Offset within the 256 byte page
	localparam int unsigned OFFSET_W = 8;
	typedef logic [OFFSET_W-1:0] offset_t;
	localparam offset_t OFFSET_LAST = '1;   // Last byte of the page

	// Sprite engine states
	// bit 0 pauses the CPU, bit 1 means the engine owns the bus
	typedef enum logic [1:0] {
		SPRITE_IDLE    = 2'b00,
		SPRITE_PENDING = 2'b01,   // Waiting for an odd CPU read to start or resume
		SPRITE_ACTIVE  = 2'b11    // Copying, read on even and write on odd
	} sprite_state_e;

	// Sample channel states
	typedef enum logic {
		SAMPLE_IDLE    = 1'b0,
		SAMPLE_GRANTED = 1'b1    // Ack follows on the next even cycle
	} sample_state_e;

endpackage

`default_nettype wire

//--- source/dma_cycle_timer.sv
//####################################################################
// DMA cycle timer
// Divides the master clock down to the CPU cycle enable and keeps
// the even/odd parity of the CPU cycles
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module dma_cycle_timer (
	input  wire  clk,
	input  wire  reset,
	output logic cpu_ce,      // One master clock wide, once per CPU cycle
	output logic odd_cycle    // Parity of the current CPU cycle
);

	dma_ctrl_pkg::divide_t count;   // Master clock position inside the CPU cycle

	// Enable on the last master clock of each CPU cycle
	assign cpu_ce = (count == dma_ctrl_pkg::DIVIDE_LAST);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= dma_ctrl_pkg::DIVIDE_FIRST;   // First enable lands on the 12th clock
		end else if (cpu_ce) begin
			count <= dma_ctrl_pkg::DIVIDE_FIRST;   // Wrap
		end else begin
			count <= count + 1'b1;
		end
	end

	// Parity flips at the end of every CPU cycle
	// Cycle after reset counts as even
	always_ff @(posedge clk) begin
		if (reset) begin
			odd_cycle <= 1'b0;
		end else if (cpu_ce) begin
			odd_cycle <= ~odd_cycle;
		end
	end

endmodule

`default_nettype wire

//--- source/nes_dma_top.sv
//####################################################################
// DMA engine top level
// Cycle timer, sprite page copy engine and bus arbiter between the
// external CPU core and memory
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module nes_dma_top (
	input  wire                         clk,
	input  wire                         reset,
	input  wire  dma_bus_pkg::cpu_bus_t cpu,              // Bus from the CPU core
	input  wire  dma_bus_pkg::data_t    mem_din,          // Read data from memory
	input  wire                         sample_request,   // Sample fetch request, level
	input  wire  dma_bus_pkg::addr_t    sample_addr,      // Sample fetch address
	output dma_bus_pkg::dma_bus_t       bus,              // Bus towards memory
	output logic                        pause_cpu,        // Stalls the CPU core
	output logic                        sample_ack,
	output logic                        cpu_ce,           // CPU cycle enable
	output logic                        odd_cycle         // CPU cycle parity
);

	logic                        oam_trigger;    // Arbiter to engine
	logic                        sample_grant;   // Arbiter to engine
	dma_ctrl_pkg::sprite_state_e sprite_state;   // Engine to arbiter
	dma_bus_pkg::addr_t          sprite_addr;
	dma_bus_pkg::data_t          sprite_data;

	dma_cycle_timer u_timer (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle)
	);

	sprite_dma_engine u_sprite (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.odd_cycle    (odd_cycle),
		.oam_trigger  (oam_trigger),
		.sample_grant (sample_grant),
		.cpu          (cpu),
		.mem_din      (mem_din),          // Latched on even copy cycles
		.sprite_state (sprite_state),
		.sprite_addr  (sprite_addr),
		.sprite_data  (sprite_data)
	);

	dma_bus_arbiter u_arbiter (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sample_request (sample_request),
		.cpu            (cpu),
		.sample_addr    (sample_addr),
		.sprite_state   (sprite_state),
		.sprite_addr    (sprite_addr),
		.sprite_data    (sprite_data),
		.oam_trigger    (oam_trigger),
		.sample_grant   (sample_grant),
		.sample_ack     (sample_ack),
		.pause_cpu      (pause_cpu),
		.bus            (bus)
	);

endmodule

`default_nettype wire

//--- source/sprite_dma_engine.sv
//####################################################################
// Sprite DMA engine
// Copies one 256 byte page to the OAM data port, reading on even
// CPU cycles and writing the latched byte on odd ones
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module sprite_dma_engine (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         cpu_ce,
	input  wire                         odd_cycle,
	input  wire                         oam_trigger,    // Write to the DMA register this cycle
	input  wire                         sample_grant,   // Sample channel holds the next even cycle
	input  wire  dma_bus_pkg::cpu_bus_t cpu,
	input  wire  dma_bus_pkg::data_t    mem_din,        // Byte returned by memory
	output dma_ctrl_pkg::sprite_state_e sprite_state,
	output dma_bus_pkg::addr_t          sprite_addr,    // Page and offset of the next read
	output dma_bus_pkg::data_t          sprite_data     // Byte for the next OAM write
);

	dma_bus_pkg::data_t    page;     // Source page, high address byte
	dma_ctrl_pkg::offset_t offset;   // Byte within the page

	logic copy_on;     // Engine owns the bus this cycle
	logic page_done;   // Write of the last byte is in progress

	assign copy_on     = (sprite_state == dma_ctrl_pkg::SPRITE_ACTIVE);
	assign page_done   = (offset == dma_ctrl_pkg::OFFSET_LAST);
	assign sprite_addr = {page, offset};

	// Copy FSM, moves only at the end of a CPU cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			sprite_state <= dma_ctrl_pkg::SPRITE_IDLE;
		end else if (cpu_ce) begin
			if (oam_trigger) begin
				sprite_state <= dma_ctrl_pkg::SPRITE_PENDING;   // CPU pauses from here on
			end else begin
				case (sprite_state)
					dma_ctrl_pkg::SPRITE_IDLE: begin
					end
					dma_ctrl_pkg::SPRITE_PENDING: begin
						// Start only once the CPU sits in a read, so the next cycle is even
						if (cpu.rnw && odd_cycle) begin
							sprite_state <= dma_ctrl_pkg::SPRITE_ACTIVE;
						end
					end
					dma_ctrl_pkg::SPRITE_ACTIVE: begin
						if (!odd_cycle && sample_grant) begin
							sprite_state <= dma_ctrl_pkg::SPRITE_PENDING;   // Even cycle went to the sample
						end else if (odd_cycle && page_done) begin
							sprite_state <= dma_ctrl_pkg::SPRITE_IDLE;      // 256th write finished
						end
					end
					default: sprite_state <= dma_ctrl_pkg::SPRITE_IDLE;
				endcase
			end
		end
	end

	// Source address
	// Offset steps after each write, so a stolen read is simply repeated
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (oam_trigger) begin
				page   <= cpu.dout;   // CPU writes the page number
				offset <= '0;
			end else if (copy_on && odd_cycle) begin
				offset <= offset + 1'b1;
			end
		end
	end

	// Byte latch, loaded at the end of each even read cycle
	always_ff @(posedge clk) begin
		if (cpu_ce && copy_on && !odd_cycle) begin
			sprite_data <= mem_din;
		end
	end

endmodule

`default_nettype wire

//--- verification/dma_vectors.txt
// Sprite DMA scenarios, three hex words per record
// page, sample request start in CPU cycles from record start (FFFF none), sample address
0002 FFFF 0000
0003 0002 C0A5
0000 0009 C000
0007 0040 F123
0045 0041 E001
00C8 0100 8F00
00FF 01FE D555

//--- verification/tb_nes_dma.sv
//####################################################################
// Testbench for the DMA engine top level
// Replays sprite page copies with sample fetches against a cycle
// reference model, over a random memory image
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_nes_dma;

	localparam int MAX_WORDS      = 48;    // Three words per record
	localparam int LEAD_CYCLES    = 8;     // CPU reads before the trigger write
	localparam int RECORD_CYCLES  = 600;   // CPU cycle budget of one record
	localparam int TIMEOUT_CLOCKS = 20;    // Master clocks allowed per CPU cycle, 12 plus margin

	// Pause and ack as seen together at the end of a CPU cycle
	typedef struct packed {
		logic pause;
		logic ack;
	} ctrl_out_t;

	logic                  clk;
	logic                  reset;
	dma_bus_pkg::cpu_bus_t cpu;
	dma_bus_pkg::data_t    mem_din;
	logic                  sample_request;
	dma_bus_pkg::addr_t    sample_addr;
	dma_bus_pkg::dma_bus_t bus;
	logic                  pause_cpu;
	logic                  sample_ack;
	logic                  cpu_ce;
	logic                  odd_cycle;

	dma_bus_pkg::data_t    mem [0:65535];           // Whole CPU address space
	logic [15:0]           vectors [0:MAX_WORDS-1];
	dma_bus_pkg::dma_bus_t oam_writes [$];          // Every OAM write seen on the bus
	logic                  ack_seen;                // Requester saw the ack last cycle
	integer                seed;
	int                    clock_count = 0;
	int                    timeout_limit = 1000000;

	// Reference model state, moves at the end of each CPU cycle
	dma_ctrl_pkg::sprite_state_e model_sprite;
	logic                        model_granted;
	logic                        model_odd;
	dma_bus_pkg::data_t          model_page;
	dma_ctrl_pkg::offset_t       model_offset;
	dma_bus_pkg::data_t          model_latch;

	nes_dma_top UUT (
		.clk            (clk),
		.reset          (reset),
		.cpu            (cpu),
		.mem_din        (mem_din),
		.sample_request (sample_request),
		.sample_addr    (sample_addr),
		.bus            (bus),
		.pause_cpu      (pause_cpu),
		.sample_ack     (sample_ack),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle)
	);

	assign mem_din = mem[bus.addr];   // Asynchronous memory read

	always #10 clk = ~clk;

	// Run limit in master clocks
	always @(posedge clk) begin
		clock_count <= clock_count + 1;
		if (clock_count > timeout_limit) begin
			$display("Timeout: the run did not finish within %0d master clocks", timeout_limit);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic compare_bus(input dma_bus_pkg::dma_bus_t got, input dma_bus_pkg::dma_bus_t exp);
		// Data only matters on a write
		if (got.addr !== exp.addr || got.read !== exp.read || got.owner !== exp.owner ||
				(!exp.read && got.data !== exp.data)) begin
			$display("Fail bus: got addr %h data %h read %h owner %h", got.addr, got.data,
				got.read, got.owner);
			$display("Fail bus: expected addr %h data %h read %h owner %h", exp.addr, exp.data,
				exp.read, exp.owner);
			abort_run();
		end
	endtask

	task automatic compare_ctrl(input ctrl_out_t got, input ctrl_out_t exp);
		if (got !== exp) begin
			$display("Fail pause_cpu/sample_ack: got %h/%h expected %h/%h", got.pause, got.ack,
				exp.pause, exp.ack);
			abort_run();
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// Expected outputs of the current CPU cycle
	task automatic predict_outputs(output dma_bus_pkg::dma_bus_t exp_bus, output ctrl_out_t exp_ctrl);
		logic ack;
		logic copying;
		ack           = model_granted && !model_odd;   // Ack is the even half of the grant
		copying       = (model_sprite == dma_ctrl_pkg::SPRITE_ACTIVE);
		exp_ctrl.ack   = ack;
		exp_ctrl.pause = (model_sprite != dma_ctrl_pkg::SPRITE_IDLE) || sample_request;
		exp_bus.owner  = ack || copying;
		exp_bus.data   = model_latch;
		if (ack) begin
			exp_bus.addr = sample_addr;
			exp_bus.read = 1'b1;
		end else if (copying && !model_odd) begin
			exp_bus.addr = {model_page, model_offset};   // Source read
			exp_bus.read = 1'b1;
		end else if (copying) begin
			exp_bus.addr = dma_bus_pkg::OAM_DATA_PORT;
			exp_bus.read = 1'b0;
		end else begin
			exp_bus.addr = cpu.addr;   // CPU owns the bus
			exp_bus.data = cpu.dout;
			exp_bus.read = cpu.rnw;
		end
	endtask

	// Move the model on by one CPU cycle
	task automatic advance_model(input dma_bus_pkg::dma_bus_t exp_bus);
		logic trigger;
		trigger = !exp_bus.owner && !exp_bus.read && exp_bus.addr == dma_bus_pkg::OAM_DMA_REG;
		if (trigger) begin
			model_sprite = dma_ctrl_pkg::SPRITE_PENDING;
			model_page   = cpu.dout;
			model_offset = '0;
		end else if (model_sprite == dma_ctrl_pkg::SPRITE_PENDING) begin
			if (cpu.rnw && model_odd) begin
				model_sprite = dma_ctrl_pkg::SPRITE_ACTIVE;
			end
		end else if (model_sprite == dma_ctrl_pkg::SPRITE_ACTIVE) begin
			if (!model_odd && model_granted) begin
				model_sprite = dma_ctrl_pkg::SPRITE_PENDING;   // Read was stolen, redo it later
			end else if (!model_odd) begin
				model_latch = mem[{model_page, model_offset}];
			end else begin
				if (model_offset == 8'hFF) begin
					model_sprite = dma_ctrl_pkg::SPRITE_IDLE;
				end
				model_offset = model_offset + dma_ctrl_pkg::offset_t'(1);
			end
		end
		// Sample channel, uses the grant of the cycle just ended
		if (!model_granted) begin
			model_granted = sample_request && cpu.rnw && !model_odd;
		end else if (!model_odd) begin
			model_granted = 1'b0;
		end
		model_odd = !model_odd;
	endtask

	// One CPU cycle, called 2 ns after a rising edge with the inputs driven
	task automatic run_cpu_cycle();
		dma_bus_pkg::dma_bus_t exp_bus;
		ctrl_out_t             exp_ctrl;
		ctrl_out_t             got_ctrl;
		int                    clocks;
		clocks = 0;
		do begin
			@(negedge clk);
			clocks++;
		end while (!cpu_ce);
		compare_count("cpu_ce period", clocks, int'(dma_ctrl_pkg::CPU_DIVIDE));
		compare_count("odd_cycle", int'(odd_cycle), int'(model_odd));
		predict_outputs(exp_bus, exp_ctrl);
		got_ctrl.pause = pause_cpu;
		got_ctrl.ack   = sample_ack;
		compare_bus(bus, exp_bus);
		compare_ctrl(got_ctrl, exp_ctrl);
		if (bus.owner && !bus.read && bus.addr == dma_bus_pkg::OAM_DATA_PORT) begin
			oam_writes.push_back(bus);
		end
		ack_seen = sample_ack;
		advance_model(exp_bus);
		@(posedge clk);
		#2;
	endtask

	// All 256 bytes of the page, in order, once each
	task automatic check_page_copy(input dma_bus_pkg::data_t page);
		dma_bus_pkg::dma_bus_t exp_bus;
		compare_count("oam write count", oam_writes.size(), 256);
		for (int i = 0; i < 256; i++) begin
			exp_bus.addr  = dma_bus_pkg::OAM_DATA_PORT;
			exp_bus.data  = mem[{page, 8'(i)}];
			exp_bus.read  = 1'b0;
			exp_bus.owner = 1'b1;
			compare_bus(oam_writes[i], exp_bus);
		end
	endtask

	task automatic play_record(input int rec);
		dma_bus_pkg::data_t page;
		int                 start;
		int                 cycle;
		logic               triggered;
		logic               copy_done;
		page        = dma_bus_pkg::data_t'(vectors[3 * rec]);
		start       = int'(vectors[3 * rec + 1]);
		sample_addr = vectors[3 * rec + 2];
		oam_writes.delete();
		triggered = 1'b0;
		copy_done = 1'b0;
		cycle     = 0;
		while (!copy_done) begin
			if (ack_seen) begin
				sample_request = 1'b0;   // Drop on the cycle after the ack
			end
			if (cycle == start) begin
				sample_request = 1'b1;
			end
			// CPU writes the trigger once nothing pauses it
			if (!triggered && cycle >= LEAD_CYCLES && !sample_request) begin
				cpu       = '{addr: dma_bus_pkg::OAM_DMA_REG, dout: page, rnw: 1'b0};
				triggered = 1'b1;
			end else if (!cpu.rnw || (model_sprite == dma_ctrl_pkg::SPRITE_IDLE && !sample_request)) begin
				// Next fetch, held as it is while paused
				cpu = '{addr: {8'h80, dma_bus_pkg::data_t'(cycle)}, dout: ~page, rnw: 1'b1};
			end
			run_cpu_cycle();
			cycle++;
			copy_done = triggered && model_sprite == dma_ctrl_pkg::SPRITE_IDLE &&
				!sample_request && !model_granted;
		end
		// Plain CPU write and read pass through
		cpu = '{addr: 16'h0300, dout: page, rnw: 1'b0};
		run_cpu_cycle();
		cpu = '{addr: 16'h0300, dout: '0, rnw: 1'b1};
		run_cpu_cycle();
		check_page_copy(page);
	endtask

	initial begin
		int record_count;
		clk            = 1'b0;
		reset          = 1'b1;
		cpu            = '{addr: 16'h8000, dout: '0, rnw: 1'b1};
		sample_request = 1'b0;
		sample_addr    = '0;
		ack_seen       = 1'b0;
		model_sprite   = dma_ctrl_pkg::SPRITE_IDLE;
		model_granted  = 1'b0;
		model_odd      = 1'b0;
		model_page     = '0;
		model_offset   = '0;
		model_latch    = '0;
		seed = 32'h757b;
		for (int i = 0; i < 65536; i++) begin
			mem[i] = dma_bus_pkg::data_t'($random(seed));
		end
		for (int i = 0; i < MAX_WORDS; i++) begin
			vectors[i] = 16'hFFFF;   // Page word above FF ends the list
		end
		$readmemh("verification/dma_vectors.txt", vectors);
		record_count = 0;
		while (record_count * 3 < MAX_WORDS && vectors[record_count * 3] <= 16'h00FF) begin
			record_count++;
		end
		if (record_count == 0) begin
			$display("No scenario records could be read from the vectors file");
			abort_run();
		end
		timeout_limit = (record_count * RECORD_CYCLES + 16) * TIMEOUT_CLOCKS;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int rec = 0; rec < record_count; rec++) begin
			play_record(rec);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
